//--- Bender.yml
package:
  name: pkt_buffer

sources:
  - hdl/buffer_pkg.sv
  - hdl/dual_port_ram.sv
  - hdl/port_a_arbiter.sv
  - hdl/cpu_result_stage.sv
  - hdl/pkt_buffer_top.sv
  - target: test
    files:
      - verification/pkt_buffer_tb.sv

//--- flist.f
hdl/buffer_pkg.sv
hdl/dual_port_ram.sv
hdl/port_a_arbiter.sv
hdl/cpu_result_stage.sv
hdl/pkt_buffer_top.sv
verification/pkt_buffer_tb.sv

//--- hdl/buffer_pkg.sv
`default_nettype none

package buffer_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    localparam int DATA_W = 256;
    localparam int KEEP_W = DATA_W / 8;
    localparam int META_W = 128;

    // one packet memory word, last on top
    typedef struct packed {
        logic              last;
        logic [KEEP_W-1:0] keep;
        logic [DATA_W-1:0] data;
    } pkt_entry_t;

    typedef logic [META_W-1:0] meta_t;

    typedef enum logic {
        SEL_PKT  = 1'b0,
        SEL_META = 1'b1
    } buf_sel_e;

    //////////////////////////////////////////////////
    // cpu side
    //////////////////////////////////////////////////
    typedef struct packed {
        logic       valid;
        logic       wr;
        buf_sel_e   sel;
        pkt_entry_t wdata;   // meta write takes low META_W bits
    } cpu_req_t;

    // access reaching port a this cycle
    typedef struct packed {
        logic     valid;
        logic     wr;
        buf_sel_e sel;
    } cpu_issue_t;

    typedef struct packed {
        logic       rd_valid;
        logic       wr_valid;
        pkt_entry_t pkt_data;
        meta_t      meta_data;
    } cpu_rsp_t;

endpackage

`default_nettype wire

//--- hdl/cpu_result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_result_stage
    import buffer_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  cpu_issue_t cpu_issue,
    input  pkt_entry_t pkt_a_dout,
    input  meta_t      meta_a_dout,
    output cpu_rsp_t   cpu_rsp
);

    logic       rd_d1;
    logic       wr_d1;
    logic       rd_valid_q;
    logic       wr_valid_q;
    pkt_entry_t pkt_q;
    meta_t      meta_q;

    // two stage strobe pipe, split into read and write
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            rd_d1      <= 1'b0;
            wr_d1      <= 1'b0;
            rd_valid_q <= 1'b0;
            wr_valid_q <= 1'b0;
        end
        else
        begin
            rd_d1      <= cpu_issue.valid && !cpu_issue.wr;
            wr_d1      <= cpu_issue.valid && cpu_issue.wr;
            rd_valid_q <= rd_d1;
            wr_valid_q <= wr_d1;
        end
    end

    // one edge behind the memory, lines up with rd_valid
    always_ff @(posedge clk)
    begin
        pkt_q  <= pkt_a_dout;
        meta_q <= meta_a_dout;
    end

    assign cpu_rsp = '{rd_valid: rd_valid_q, wr_valid: wr_valid_q,
                       pkt_data: pkt_q, meta_data: meta_q};

endmodule

`default_nettype wire

//--- hdl/dual_port_ram.sv
`timescale 1ns/1ps
`default_nettype none

// behavioural dual port memory, port b read only
module dual_port_ram #(
    parameter type entry_t = logic [7:0],
    parameter int  ADDR_W  = 12
) (
    input  logic              clk,
    input  logic              a_we,
    input  logic [ADDR_W-1:0] a_addr,
    input  entry_t            a_din,
    output entry_t            a_dout,
    input  logic [ADDR_W-1:0] b_addr,
    output entry_t            b_dout,
    input  logic              rstn
);

    localparam int DEPTH = 1 << ADDR_W;

    entry_t mem [0:DEPTH-1];

    // port a, read first
    always_ff @(posedge clk)
    begin
        if (a_we)
        begin
            mem[a_addr] <= a_din;
        end
        a_dout <= mem[a_addr];
    end

    // port b, datapath read
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            b_dout <= '0;
        end
        else
        begin
            b_dout <= mem[b_addr];   // old word on same-edge write
        end
    end

endmodule

`default_nettype wire

//--- hdl/pkt_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_buffer_top
    import buffer_pkg::*;
#(
    parameter int ADDR_W = 12
) (
    input  logic              clk,
    input  logic              rstn,

    // datapath write, both memories at one address
    input  logic              dp_wr_en,
    input  logic [ADDR_W-1:0] dp_wr_addr,
    input  pkt_entry_t        dp_wr_entry,
    input  meta_t             dp_wr_meta,

    // datapath read
    input  logic [ADDR_W-1:0] dp_rd_addr,
    output pkt_entry_t        m_entry,
    output meta_t             m_meta,

    // cpu side
    input  cpu_req_t          cpu_req,
    input  logic [ADDR_W-1:0] cpu_addr,
    output cpu_rsp_t          cpu_rsp
);

    logic              pkt_we;
    logic              meta_we;
    logic [ADDR_W-1:0] pkt_addr;
    logic [ADDR_W-1:0] meta_addr;
    pkt_entry_t        pkt_din;
    meta_t             meta_din;
    cpu_issue_t        cpu_issue;

    pkt_entry_t        pkt_a_dout;
    meta_t             meta_a_dout;

    //////////////////////////////////////////////////
    // port a sharing
    //////////////////////////////////////////////////
    port_a_arbiter #(
        .ADDR_W (ADDR_W)
    ) u_arbiter (
        .clk         (clk),
        .rstn        (rstn),
        .dp_wr_en    (dp_wr_en),
        .dp_wr_addr  (dp_wr_addr),
        .dp_wr_entry (dp_wr_entry),
        .dp_wr_meta  (dp_wr_meta),
        .cpu_req     (cpu_req),
        .cpu_addr    (cpu_addr),
        .pkt_we      (pkt_we),
        .meta_we     (meta_we),
        .pkt_addr    (pkt_addr),
        .meta_addr   (meta_addr),
        .pkt_din     (pkt_din),
        .meta_din    (meta_din),
        .cpu_issue   (cpu_issue)
    );

    //////////////////////////////////////////////////
    // memories, shared address space
    //////////////////////////////////////////////////
    dual_port_ram #(
        .entry_t (pkt_entry_t),
        .ADDR_W  (ADDR_W)
    ) pkt_ram (
        .clk    (clk),
        .a_we   (pkt_we),
        .a_addr (pkt_addr),
        .a_din  (pkt_din),
        .a_dout (pkt_a_dout),
        .b_addr (dp_rd_addr),
        .b_dout (m_entry),
        .rstn   (rstn)
    );

    dual_port_ram #(
        .entry_t (meta_t),
        .ADDR_W  (ADDR_W)
    ) meta_ram (
        .clk    (clk),
        .a_we   (meta_we),
        .a_addr (meta_addr),
        .a_din  (meta_din),
        .a_dout (meta_a_dout),
        .b_addr (dp_rd_addr),
        .b_dout (m_meta),
        .rstn   (rstn)
    );

    // completion strobes and read data
    cpu_result_stage u_result (
        .clk         (clk),
        .rstn        (rstn),
        .cpu_issue   (cpu_issue),
        .pkt_a_dout  (pkt_a_dout),
        .meta_a_dout (meta_a_dout),
        .cpu_rsp     (cpu_rsp)
    );

endmodule

`default_nettype wire

//--- hdl/port_a_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module port_a_arbiter
    import buffer_pkg::*;
#(
    parameter int ADDR_W = 12
) (
    input  logic              clk,
    input  logic              rstn,

    input  logic              dp_wr_en,
    input  logic [ADDR_W-1:0] dp_wr_addr,
    input  pkt_entry_t        dp_wr_entry,
    input  meta_t             dp_wr_meta,

    input  cpu_req_t          cpu_req,
    input  logic [ADDR_W-1:0] cpu_addr,

    output logic              pkt_we,
    output logic              meta_we,
    output logic [ADDR_W-1:0] pkt_addr,
    output logic [ADDR_W-1:0] meta_addr,
    output pkt_entry_t        pkt_din,
    output meta_t             meta_din,
    output cpu_issue_t        cpu_issue
);

    typedef enum logic {
        ST_IDLE    = 1'b0,
        ST_WAIT_DP = 1'b1
    } state_e;

    state_e state;
    state_e state_next;

    // deferred request, only meaningful in ST_WAIT_DP
    cpu_req_t          pend_req;
    logic [ADDR_W-1:0] pend_addr;

    cpu_req_t          cur_req;
    logic [ADDR_W-1:0] cur_addr;
    logic              hold;

    // datapath owns port a, park the request
    assign hold = (state == ST_IDLE) && dp_wr_en && cpu_req.valid;

    //////////////////////////////////////////////////
    // port a mux
    //////////////////////////////////////////////////
    always_comb
    begin
        cur_req  = (state == ST_WAIT_DP) ? pend_req : cpu_req;
        cur_addr = (state == ST_WAIT_DP) ? pend_addr : cpu_addr;

        // default is the datapath write into both memories
        pkt_we    = dp_wr_en;
        meta_we   = dp_wr_en;
        pkt_addr  = dp_wr_addr;
        meta_addr = dp_wr_addr;
        pkt_din   = dp_wr_entry;
        meta_din  = dp_wr_meta;
        cpu_issue = '0;

        if (!dp_wr_en && cur_req.valid)
        begin
            cpu_issue.valid = 1'b1;
            cpu_issue.wr    = cur_req.wr;
            cpu_issue.sel   = cur_req.sel;

            if (cur_req.sel == SEL_PKT)
            begin
                pkt_we   = cur_req.wr;   // low for a read
                pkt_addr = cur_addr;
                pkt_din  = cur_req.wdata;
            end
            else
            begin
                meta_we   = cur_req.wr;
                meta_addr = cur_addr;
                meta_din  = cur_req.wdata[META_W-1:0];
            end
        end
    end

    //////////////////////////////////////////////////
    // fsm
    //////////////////////////////////////////////////
    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:
            begin
                if (hold)
                begin
                    state_next = ST_WAIT_DP;
                end
            end
            ST_WAIT_DP:
            begin
                // new requests are dropped here
                if (!dp_wr_en)
                begin
                    state_next = ST_IDLE;
                end
            end
            default:
            begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (hold)
        begin
            pend_req  <= cpu_req;
            pend_addr <= cpu_addr;
        end
    end

endmodule

`default_nettype wire

//--- verification/pkt_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_buffer_tb
    import buffer_pkg::*;
();

    localparam int ADDR_W  = 6;
    localparam int TIMEOUT = 20;
    localparam int HOLD    = 4;    // cycles the datapath keeps port a

    logic              clk = 1'b0;
    logic              rstn;
    logic              dp_wr_en;
    logic [ADDR_W-1:0] dp_wr_addr;
    pkt_entry_t        dp_wr_entry;
    meta_t             dp_wr_meta;
    logic [ADDR_W-1:0] dp_rd_addr;
    pkt_entry_t        m_entry;
    meta_t             m_meta;
    cpu_req_t          cpu_req;
    logic [ADDR_W-1:0] cpu_addr;
    cpu_rsp_t          cpu_rsp;

    int seed            = 1594;
    int checks          = 0;
    int errors          = 0;
    int tests           = 0;
    int errors_at_start = 0;
    int addrs [6]       = '{3, 8, 17, 20, 40, 63};

    // reference copies of both memories
    pkt_entry_t pkt_model [int];
    meta_t      meta_model [int];

    always #20 clk = ~clk;

    pkt_buffer_top #(
        .ADDR_W (ADDR_W)
    ) UUT (
        .clk         (clk),
        .rstn        (rstn),
        .dp_wr_en    (dp_wr_en),
        .dp_wr_addr  (dp_wr_addr),
        .dp_wr_entry (dp_wr_entry),
        .dp_wr_meta  (dp_wr_meta),
        .dp_rd_addr  (dp_rd_addr),
        .m_entry     (m_entry),
        .m_meta      (m_meta),
        .cpu_req     (cpu_req),
        .cpu_addr    (cpu_addr),
        .cpu_rsp     (cpu_rsp)
    );

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    task automatic check_word(input string name, input logic [288:0] exp,
                              input logic [288:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            $display("CHECK FAILED %s expected %0h got %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic make_entry(output pkt_entry_t e);
        for (int i = 0; i < DATA_W / 32; i++)
        begin
            e.data[i*32 +: 32] = $random(seed);
        end
        e.keep = $random(seed);
        e.last = ($random(seed) % 2) != 0;
    endtask

    task automatic make_meta(output meta_t m);
        for (int i = 0; i < META_W / 32; i++)
        begin
            m[i*32 +: 32] = $random(seed);
        end
    endtask

    // drives one cycle of datapath write, caller advances the clock
    task automatic write_datapath(input int addr);
        pkt_entry_t e;
        meta_t      m;
        make_entry(e);
        make_meta(m);
        dp_wr_en    = 1'b1;
        dp_wr_addr  = addr;
        dp_wr_entry = e;
        dp_wr_meta  = m;
        pkt_model[addr]  = e;
        meta_model[addr] = m;
    endtask

    task automatic read_datapath(input int addr);
        dp_rd_addr = addr;
        @(negedge clk);
        check_word("m_entry", pkt_model[addr], m_entry);
        check_word("m_meta", meta_model[addr], m_meta);
    endtask

    task automatic issue_cpu(input logic wr, input buf_sel_e sel, input int addr,
                             input pkt_entry_t wdata);
        cpu_req.valid = 1'b1;
        cpu_req.wr    = wr;
        cpu_req.sel   = sel;
        cpu_req.wdata = wdata;
        cpu_addr      = addr;
        if (wr && sel == SEL_PKT)
            pkt_model[addr] = wdata;
        else if (wr)
            meta_model[addr] = wdata[META_W-1:0];
    endtask

    // counts falling edges from now until the strobe
    task automatic wait_rsp(input logic rd, output int cycles);
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
            cpu_req.valid = 1'b0;   // request lasts one cycle
            seen = rd ? cpu_rsp.rd_valid : cpu_rsp.wr_valid;
        end
        assert (seen)
        else
        begin
            $display("timeout, no %s strobe within %0d cycles",
                     rd ? "rd_valid" : "wr_valid", TIMEOUT);
            errors++;
        end
    endtask

    task automatic compare_read(input buf_sel_e sel, input int addr);
        if (sel == SEL_PKT)
            check_word("cpu_rsp.pkt_data", pkt_model[addr], cpu_rsp.pkt_data);
        else
            check_word("cpu_rsp.meta_data", meta_model[addr], cpu_rsp.meta_data);
    endtask

    task automatic strobes_low();
        check_word("cpu_rsp.rd_valid", 1'b0, cpu_rsp.rd_valid);
        check_word("cpu_rsp.wr_valid", 1'b0, cpu_rsp.wr_valid);
    endtask

    // finishes an issued access, strobe two edges out and one cycle wide
    task automatic finish_access(input logic wr, input buf_sel_e sel, input int addr);
        int cycles;
        wait_rsp(!wr, cycles);
        check_word(wr ? "wr_valid latency" : "rd_valid latency", 2, cycles);
        check_word(wr ? "cpu_rsp.rd_valid" : "cpu_rsp.wr_valid", 1'b0,
                   wr ? cpu_rsp.rd_valid : cpu_rsp.wr_valid);
        if (!wr)
            compare_read(sel, addr);
        @(negedge clk);
        strobes_low();
    endtask

    task automatic cpu_round(input logic wr, input buf_sel_e sel, input int addr);
        pkt_entry_t w;
        make_entry(w);
        issue_cpu(wr, sel, addr, w);
        finish_access(wr, sel, addr);
    endtask

    // request lands while the datapath writes base, base+1, ...
    task automatic hold_access(input logic wr, input buf_sel_e sel, input int addr,
                               input int base);
        pkt_entry_t w;
        make_entry(w);
        write_datapath(base);
        issue_cpu(wr, sel, addr, w);
        for (int i = 1; i < HOLD; i++)
        begin
            @(negedge clk);
            cpu_req.valid = 1'b0;
            strobes_low();
            write_datapath(base + i);
        end
        @(negedge clk);
        strobes_low();
        dp_wr_en = 1'b0;   // pending request goes out now
        finish_access(wr, sel, addr);
    endtask

    task automatic test_done(input string name);
        tests++;
        $display("test %0d %s: %s", tests, name,
                 (errors == errors_at_start) ? "ok" : "FAILED");
        errors_at_start = errors;
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    initial
    begin
        rstn        = 1'b0;
        dp_wr_en    = 1'b0;
        dp_wr_addr  = '0;
        dp_wr_entry = '0;
        dp_wr_meta  = '0;
        dp_rd_addr  = '0;
        cpu_req     = '0;
        cpu_addr    = '0;

        repeat (16) @(posedge clk);
        @(negedge clk);
        check_word("m_entry", '0, m_entry);
        check_word("m_meta", '0, m_meta);
        strobes_low();
        rstn = 1'b1;
        repeat (4)
        begin
            @(negedge clk);
            strobes_low();
        end
        test_done("reset");

        foreach (addrs[i])
        begin
            write_datapath(addrs[i]);
            @(negedge clk);
        end
        dp_wr_en = 1'b0;
        foreach (addrs[i])
            read_datapath(addrs[i]);
        test_done("datapath write and read");

        cpu_round(1'b0, SEL_PKT, 17);
        cpu_round(1'b0, SEL_META, 40);
        cpu_round(1'b1, SEL_PKT, 3);
        cpu_round(1'b1, SEL_META, 8);
        read_datapath(3);
        read_datapath(8);
        cpu_round(1'b0, SEL_PKT, 3);
        cpu_round(1'b0, SEL_META, 8);
        test_done("cpu access with datapath idle");

        hold_access(1'b1, SEL_PKT, 20, 48);
        hold_access(1'b0, SEL_META, 49, 52);   // word written in the first hold
        cpu_round(1'b0, SEL_PKT, 20);
        read_datapath(20);
        test_done("cpu access held by datapath write");

        issue_cpu(1'b0, SEL_PKT, 17, '0);
        @(negedge clk);
        strobes_low();
        issue_cpu(1'b0, SEL_META, 63, '0);
        @(negedge clk);
        cpu_req.valid = 1'b0;
        check_word("cpu_rsp.rd_valid", 1'b1, cpu_rsp.rd_valid);
        compare_read(SEL_PKT, 17);
        @(negedge clk);
        check_word("cpu_rsp.rd_valid", 1'b1, cpu_rsp.rd_valid);
        compare_read(SEL_META, 63);
        @(negedge clk);
        strobes_low();
        test_done("back to back cpu reads");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
